/* source/periph_types_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// peripheral bus types and the address map of the timer subsystem.
////////////////////////////////////////////////////////////////////////////

package periph_types_pkg;

    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [DATA_WIDTH/8-1:0] strb_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;

    // two timers, each decoding a 16 byte window.
    localparam int TIMER_COUNT       = 2;
    localparam int TIMER_WINDOW_BITS = 4;

    localparam addr_t TIMER0_BASE = 12'h000;
    localparam addr_t TIMER1_BASE = 12'h010;

    // AXI response codes, EXOKAY and DECERR are never produced.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

/* source/timer_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// interval timer register layouts and local register addresses.
////////////////////////////////////////////////////////////////////////////

package timer_pkg;

    import periph_types_pkg::*;

    // register select comes from address bits 3:2.
    localparam int LOCAL_ADDRESS_WIDTH = 2;

    typedef enum logic [LOCAL_ADDRESS_WIDTH-1:0] {
        CONTROL_ADDRESS = 2'd0,
        STATUS_ADDRESS  = 2'd1,
        REFILL_ADDRESS  = 2'd2,
        COUNT_ADDRESS   = 2'd3
    } local_address_e;

    typedef struct packed {
        logic [DATA_WIDTH-4:0] reserved;
        logic                  irq_enable;
        logic                  one_shot;     // stop at expiry.
        logic                  count_enable;
    } control_reg_t;

    typedef struct packed {
        logic [DATA_WIDTH-2:0] reserved;
        logic                  event_flag;   // write 1 to clear.
    } status_reg_t;

endpackage

/* source/periph_bus_if.sv */
////////////////////////////////////////////////////////////////////////////
// internal peripheral bus, single cycle accesses with byte strobes.
// carries the masked write and write-1-to-clear helpers for responders.
////////////////////////////////////////////////////////////////////////////

interface periph_bus_if
    import periph_types_pkg::*;
(
    input logic bus,
    input logic rst
);

    logic  valid;
    logic  write;
    addr_t address;
    word_t wdata;
    strb_t strb;
    word_t rdata;
    logic  ready;
    logic  error;
    logic  irq;

    function automatic logic write_enabled();
        return valid && write;
    endfunction

    // strobed bytes of old take the new data.
    function automatic word_t write_into(word_t old);
        word_t merged;
        merged = old;
        for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

    function automatic word_t clear_into(word_t old);
        word_t mask;
        mask = '0;
        for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            if (strb[i]) begin
                mask[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return old & ~mask;
    endfunction

    modport m (
        input  bus, rst, rdata, ready, error, irq,
        output valid, write, address, wdata, strb
    );

    modport s (
        input  bus, rst, valid, write, address, wdata, strb,
        output rdata, ready, error, irq,
        import write_enabled, write_into, clear_into
    );

endinterface

/* source/axil_bus_bridge.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite slave bridge, one peripheral bus access per transaction.
////////////////////////////////////////////////////////////////////////////

module axil_bus_bridge
    import periph_types_pkg::*;
(
    input  logic      bus,
    input  logic      rst,
    input  addr_t     awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_e bresp,
    output logic      bvalid,
    input  logic      bready,
    input  addr_t     araddr,
    input  logic      arvalid,
    output logic      arready,
    output word_t     rdata,
    output axi_resp_e rresp,
    output logic      rvalid,
    input  logic      rready,
    periph_bus_if.m   host_bus
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WRITE_RESP,
        READ_RESP
    } state_e;

    state_e    state;
    logic      take_write;
    logic      take_read;
    logic      req_write;
    addr_t     req_address;
    word_t     req_wdata;
    strb_t     req_strb;
    word_t     resp_data;
    axi_resp_e resp_code;

    // write wins over a read arriving in the same cycle.
    assign take_write = (state == IDLE) && awvalid && wvalid;
    assign take_read  = (state == IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = take_write;
    assign wready  = take_write;
    assign arready = take_read;

    always_ff @(posedge bus) begin
        if (rst) begin
            state <= IDLE;
        end
        else begin
            case (state)
                IDLE: if (take_write || take_read) state <= ACCESS;
                ACCESS: begin
                    if (host_bus.ready) begin
                        state <= req_write ? WRITE_RESP : READ_RESP;
                    end
                end
                WRITE_RESP: if (bready) state <= IDLE;
                READ_RESP: if (rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge bus) begin
        if (take_write) begin
            req_write   <= 1'b1;
            req_address <= awaddr;
            req_wdata   <= wdata;
            req_strb    <= wstrb;
        end
        else if (take_read) begin
            req_write   <= 1'b0;
            req_address <= araddr;
            req_wdata   <= '0;
            req_strb    <= '1;   // reads see the whole word.
        end
        if (state == ACCESS && host_bus.ready) begin
            resp_data <= host_bus.rdata;
            resp_code <= host_bus.error ? SLVERR : OKAY;
        end
    end

    assign host_bus.valid   = (state == ACCESS);
    assign host_bus.write   = req_write;
    assign host_bus.address = req_address;
    assign host_bus.wdata   = req_wdata;
    assign host_bus.strb    = req_strb;

    // response is held until the host takes it.
    assign bvalid = (state == WRITE_RESP);
    assign bresp  = resp_code;
    assign rvalid = (state == READ_RESP);
    assign rresp  = resp_code;
    assign rdata  = resp_data;

endmodule

/* source/periph_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// address decoder for the two timer windows that also merges the interrupts.
////////////////////////////////////////////////////////////////////////////

module periph_decoder
    import periph_types_pkg::*;
(
    periph_bus_if.s host_bus,
    periph_bus_if.m timer_bus0,
    periph_bus_if.m timer_bus1,
    output logic    irq
);

    logic [TIMER_COUNT-1:0] hit;
    logic [TIMER_COUNT-1:0] irq_lines;

    // compare the window bits only.
    assign hit[0] = host_bus.address[ADDR_WIDTH-1:TIMER_WINDOW_BITS]
                    == TIMER0_BASE[ADDR_WIDTH-1:TIMER_WINDOW_BITS];
    assign hit[1] = host_bus.address[ADDR_WIDTH-1:TIMER_WINDOW_BITS]
                    == TIMER1_BASE[ADDR_WIDTH-1:TIMER_WINDOW_BITS];

    assign timer_bus0.valid   = host_bus.valid && hit[0];
    assign timer_bus0.write   = host_bus.write;
    assign timer_bus0.address = host_bus.address;
    assign timer_bus0.wdata   = host_bus.wdata;
    assign timer_bus0.strb    = host_bus.strb;

    assign timer_bus1.valid   = host_bus.valid && hit[1];
    assign timer_bus1.write   = host_bus.write;
    assign timer_bus1.address = host_bus.address;
    assign timer_bus1.wdata   = host_bus.wdata;
    assign timer_bus1.strb    = host_bus.strb;

    always_comb begin
        case (hit)
            2'b01: begin
                host_bus.rdata = timer_bus0.rdata;
                host_bus.ready = timer_bus0.ready;
                host_bus.error = 1'b0;
            end
            2'b10: begin
                host_bus.rdata = timer_bus1.rdata;
                host_bus.ready = timer_bus1.ready;
                host_bus.error = 1'b0;
            end
            default: begin
                // unmapped address answers at once with an error.
                host_bus.rdata = '0;
                host_bus.ready = host_bus.valid;
                host_bus.error = 1'b1;
            end
        endcase
    end

    assign irq_lines    = {timer_bus1.irq, timer_bus0.irq};
    assign irq          = |irq_lines;

endmodule

/* source/interval_timer.sv */
////////////////////////////////////////////////////////////////////////////
// interval timer that counts down to zero and reloads from refill.
// one-shot mode stops the count at expiry.
////////////////////////////////////////////////////////////////////////////

module interval_timer
    import periph_types_pkg::*;
    import timer_pkg::*;
(
    periph_bus_if.s tbus
);

    local_address_e local_address;
    control_reg_t   control_reg;
    status_reg_t    status_reg;
    word_t          refill_reg;
    word_t          count_reg;
    word_t          refill_next;
    logic           expired;

    assign local_address = local_address_e'(tbus.address[2 +: LOCAL_ADDRESS_WIDTH]);

    assign expired     = control_reg.count_enable && (count_reg == '0);
    assign refill_next = tbus.write_into(refill_reg);

    always_ff @(posedge tbus.bus) begin
        if (tbus.rst) begin
            control_reg <= '0;
        end
        else if (tbus.write_enabled() && local_address == CONTROL_ADDRESS) begin
            control_reg <= control_reg_t'(tbus.write_into(word_t'(control_reg)));
        end
        else if (expired && control_reg.one_shot) begin
            control_reg.count_enable <= 1'b0;
        end
    end

    always_ff @(posedge tbus.bus) begin
        if (tbus.rst) begin
            status_reg <= '0;
        end
        else if (tbus.write_enabled() && local_address == STATUS_ADDRESS) begin
            status_reg <= status_reg_t'(tbus.clear_into(word_t'(status_reg)));
        end
        else if (expired) begin
            status_reg.event_flag <= 1'b1;
        end
    end

    always_ff @(posedge tbus.bus) begin
        if (tbus.rst) begin
            refill_reg <= '0;
            count_reg  <= '0;
        end
        else if (tbus.write_enabled() && local_address == REFILL_ADDRESS) begin
            refill_reg <= refill_next;
            count_reg  <= refill_next;    // restart from the new value.
        end
        else if (control_reg.count_enable && count_reg != '0) begin
            count_reg <= count_reg - 1'b1;
        end
        else begin
            count_reg <= refill_reg;      // reload at zero and track while idle.
        end
    end

    always_comb begin
        case (local_address)
            CONTROL_ADDRESS: tbus.rdata = word_t'(control_reg);
            STATUS_ADDRESS:  tbus.rdata = word_t'(status_reg);
            REFILL_ADDRESS:  tbus.rdata = refill_reg;
            default:         tbus.rdata = count_reg;
        endcase
    end

    assign tbus.ready = tbus.valid;
    assign tbus.irq   = status_reg.event_flag && control_reg.irq_enable;

endmodule

/* source/timer_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// timer subsystem, AXI4-Lite bridge, decoder and two interval timers.
////////////////////////////////////////////////////////////////////////////

module timer_subsystem
    import periph_types_pkg::*;
(
    input  logic      bus,
    input  logic      rst,
    input  addr_t     awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_e bresp,
    output logic      bvalid,
    input  logic      bready,
    input  addr_t     araddr,
    input  logic      arvalid,
    output logic      arready,
    output word_t     rdata,
    output axi_resp_e rresp,
    output logic      rvalid,
    input  logic      rready,
    output logic      irq
);

    periph_bus_if host_bus   (.bus(bus), .rst(rst));
    periph_bus_if timer_bus0 (.bus(bus), .rst(rst));
    periph_bus_if timer_bus1 (.bus(bus), .rst(rst));

    axil_bus_bridge bridge (
        .bus      (bus),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .host_bus (host_bus.m)
    );

    periph_decoder decoder (
        .host_bus   (host_bus.s),
        .timer_bus0 (timer_bus0.m),
        .timer_bus1 (timer_bus1.m),
        .irq        (irq)
    );

    interval_timer timer0 (.tbus(timer_bus0.s));
    interval_timer timer1 (.tbus(timer_bus1.s));

endmodule

/* tb/axil_host_tasks.svh */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite host tasks and the xorshift source of the testbench.
////////////////////////////////////////////////////////////////////////////

`ifndef AXIL_HOST_TASKS_SVH
`define AXIL_HOST_TASKS_SVH

localparam int WAIT_LIMIT = 20;

int    value_errors    = 0;
int    protocol_errors = 0;
int    timeout_errors  = 0;
word_t rng_state       = 32'h84b3;

function automatic word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// strobed bytes take the new data.
function automatic word_t merge_bytes(word_t old, word_t data, strb_t strobes);
    word_t result;
    result = old;
    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
        if (strobes[b]) begin
            result[8*b +: 8] = data[8*b +: 8];
        end
    end
    return result;
endfunction

task automatic report_timeout(input string what);
    timeout_errors = timeout_errors + 1;
    $display("timeout at %0t while waiting for %s", $time, what);
endtask

// hold > 0 keeps bready low that many cycles with new requests pending.
task automatic axil_write(input addr_t address, input word_t data, input strb_t strobes,
                          input int hold, output axi_resp_e resp);
    int   cycles;
    logic accepted;
    resp    = SLVERR;
    awaddr  = address;
    wdata   = data;
    wstrb   = strobes;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    do begin
        @(negedge bus);
        cycles++;
    end while (!(awready && wready) && cycles < WAIT_LIMIT);
    accepted = awready && wready;
    @(posedge bus);
    #10;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!accepted) begin
        report_timeout("awready and wready");
        return;
    end
    awvalid = (hold > 0);   // competing requests.
    wvalid  = (hold > 0);
    arvalid = (hold > 0);
    araddr  = address;
    bready  = (hold == 0);
    cycles  = 0;
    do begin
        @(negedge bus);
        cycles++;
    end while (!bvalid && cycles < WAIT_LIMIT);
    if (!bvalid) begin
        report_timeout("bvalid");
    end
    resp = bresp;
    for (int i = 0; i < hold && bvalid; i++) begin
        @(posedge bus);
        #10;
        @(negedge bus);
        assert (bvalid && !awready && !arready) else begin
            protocol_errors = protocol_errors + 1;
            $display("write response dropped or a new request taken under back-pressure");
        end
    end
    if (hold > 0) begin
        @(posedge bus);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b1;
    end
    @(posedge bus);
    #10;
    bready = 1'b0;
endtask

// rready stays low for one cycle after rvalid rises.
task automatic axil_read(input addr_t address, output word_t data, output axi_resp_e resp);
    int   cycles;
    logic accepted;
    data    = '0;
    resp    = SLVERR;
    araddr  = address;
    arvalid = 1'b1;
    cycles  = 0;
    do begin
        @(negedge bus);
        cycles++;
    end while (!arready && cycles < WAIT_LIMIT);
    accepted = arready;
    @(posedge bus);
    #10;
    arvalid = 1'b0;
    if (!accepted) begin
        report_timeout("arready");
        return;
    end
    rready = 1'b0;
    cycles = 0;
    do begin
        @(negedge bus);
        cycles++;
    end while (!rvalid && cycles < WAIT_LIMIT);
    if (!rvalid) begin
        report_timeout("rvalid");
    end
    @(posedge bus);
    #10;
    rready = 1'b1;
    @(negedge bus);
    data = rdata;
    resp = rresp;
    @(posedge bus);
    #10;
    rready = 1'b0;
endtask

`endif

/* tb/timer_subsystem_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the timer subsystem over AXI4-Lite.
////////////////////////////////////////////////////////////////////////////

module timer_subsystem_tb
    import periph_types_pkg::*;
    import timer_pkg::*;
();

    localparam int POLL_LIMIT = 30;

    logic      bus;
    logic      rst;
    addr_t     awaddr;
    logic      awvalid;
    logic      awready;
    word_t     wdata;
    strb_t     wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_e bresp;
    logic      bvalid;
    logic      bready;
    addr_t     araddr;
    logic      arvalid;
    logic      arready;
    word_t     rdata;
    axi_resp_e rresp;
    logic      rvalid;
    logic      rready;
    logic      irq;

    word_t exp_control [TIMER_COUNT];   // expected contents per timer.
    word_t exp_status  [TIMER_COUNT];
    word_t exp_refill  [TIMER_COUNT];

    `include "axil_host_tasks.svh"

    timer_subsystem uut (.*);

    initial begin
        bus = 1'b0;
        forever begin
            #50 bus = ~bus;
        end
    end

    task automatic count_protocol_error(input string what);
        protocol_errors = protocol_errors + 1;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    a_reset_idle: assert property (@(posedge bus)
        rst |=> !bvalid && !rvalid && !irq && !uut.host_bus.valid)
        else count_protocol_error("response or access active after reset");
    a_no_write: assert property (@(posedge bus) disable iff (rst)
        !(awvalid && wvalid) |-> !awready && !wready)
        else count_protocol_error("awready or wready without a write request");
    a_no_read: assert property (@(posedge bus) disable iff (rst)
        arready |-> arvalid && !(awvalid && wvalid))
        else count_protocol_error("read accepted without request or over a write");
    a_write_pair: assert property (@(posedge bus) disable iff (rst) awready == wready)
        else count_protocol_error("awready and wready apart");
    a_write_access: assert property (@(posedge bus) disable iff (rst)
        awready |=> uut.host_bus.valid && uut.host_bus.write && !awready)
        else count_protocol_error("write access did not follow the handshake");
    a_read_access: assert property (@(posedge bus) disable iff (rst)
        arready |=> uut.host_bus.valid && !uut.host_bus.write && !arready)
        else count_protocol_error("read access did not follow the handshake");
    a_single_cycle: assert property (@(posedge bus) disable iff (rst)
        uut.host_bus.valid |-> uut.host_bus.ready)
        else count_protocol_error("internal access not answered in its cycle");
    a_bvalid_rise: assert property (@(posedge bus) disable iff (rst)
        uut.host_bus.valid && uut.host_bus.write |=> bvalid)
        else count_protocol_error("bvalid late after the write access");
    a_rvalid_rise: assert property (@(posedge bus) disable iff (rst)
        uut.host_bus.valid && !uut.host_bus.write |=> rvalid)
        else count_protocol_error("rvalid late after the read access");
    a_bvalid_hold: assert property (@(posedge bus) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else count_protocol_error("write response changed before bready");
    a_rvalid_hold: assert property (@(posedge bus) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else count_protocol_error("read response changed before rready");
    a_busy: assert property (@(posedge bus) disable iff (rst)
        bvalid || rvalid |-> !awready && !arready)
        else count_protocol_error("address accepted while a response is pending");

    task automatic check_word(input string name, input word_t got, input word_t expected);
        assert (got == expected) else begin
            value_errors = value_errors + 1;
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, expected);
        end
    endtask

    function automatic addr_t reg_address(int timer, local_address_e which);
        addr_t base;
        base = (timer == 0) ? TIMER0_BASE : TIMER1_BASE;
        return base | addr_t'({which, 2'b00});
    endfunction

    task automatic read_expect(input addr_t address, input word_t expected, input string name);
        word_t     data;
        axi_resp_e resp;
        axil_read(address, data, resp);
        check_word({"rresp ", name}, word_t'(resp), word_t'(OKAY));
        check_word({"rdata ", name}, data, expected);
    endtask

    task automatic write_reg(input int timer, input local_address_e which,
                             input word_t data, input strb_t strobes);
        axi_resp_e resp;
        axil_write(reg_address(timer, which), data, strobes, 0, resp);
        check_word("bresp", word_t'(resp), word_t'(OKAY));
        case (which)
            CONTROL_ADDRESS: exp_control[timer] = merge_bytes(exp_control[timer], data, strobes);
            STATUS_ADDRESS:  exp_status[timer] = exp_status[timer] & ~merge_bytes('0, data, strobes);
            REFILL_ADDRESS:  exp_refill[timer] = merge_bytes(exp_refill[timer], data, strobes);
            default: ;
        endcase
    endtask

    // count tracks refill while the timer is disabled.
    task automatic check_timer_regs(input int timer);
        read_expect(reg_address(timer, CONTROL_ADDRESS), exp_control[timer],
                    $sformatf("timer%0d control", timer));
        read_expect(reg_address(timer, STATUS_ADDRESS), exp_status[timer],
                    $sformatf("timer%0d status", timer));
        read_expect(reg_address(timer, REFILL_ADDRESS), exp_refill[timer],
                    $sformatf("timer%0d refill", timer));
        read_expect(reg_address(timer, COUNT_ADDRESS), exp_refill[timer],
                    $sformatf("timer%0d count", timer));
    endtask

    task automatic wait_for_event(input int timer);
        word_t     data;
        axi_resp_e resp;
        int        polls;
        polls = 0;
        data  = '0;
        while (!data[0] && polls < POLL_LIMIT) begin
            axil_read(reg_address(timer, COUNT_ADDRESS), data, resp);
            assert (data <= exp_refill[timer]) else begin
                value_errors = value_errors + 1;
                $display("Mismatch count: 0x%08h above refill 0x%08h", data, exp_refill[timer]);
            end
            check_word("irq", word_t'(irq), '0);
            axil_read(reg_address(timer, STATUS_ADDRESS), data, resp);
            polls++;
        end
        if (!data[0]) begin
            report_timeout($sformatf("event_flag of timer %0d", timer));
        end
        exp_status[timer] = 32'h1;
    endtask

    initial begin
        word_t     data;
        axi_resp_e resp;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        exp_control = '{default: '0};
        exp_status  = '{default: '0};
        exp_refill  = '{default: '0};
        repeat (5) @(posedge bus);
        #10;
        rst = 1'b0;

        // quiet bus right after reset.
        for (int i = 0; i < 3; i++) begin
            @(negedge bus);
            check_word("awready wready arready bvalid rvalid irq",
                       word_t'({awready, wready, arready, bvalid, rvalid, irq}), '0);
        end
        @(posedge bus);
        #10;
        check_timer_regs(0);
        check_timer_regs(1);

        for (int t = 0; t < TIMER_COUNT; t++) begin
            for (int i = 0; i < 5; i++) begin
                write_reg(t, CONTROL_ADDRESS, next_random() & ~32'h1, strb_t'(next_random()));
                write_reg(t, REFILL_ADDRESS, next_random(), strb_t'(next_random()));
                check_timer_regs(t);
            end
        end

        // periodic counting on timer 0.
        write_reg(0, REFILL_ADDRESS, 32'd5, 4'hf);
        write_reg(0, CONTROL_ADDRESS, (exp_control[0] & ~32'h7) | 32'h1, 4'hf);
        wait_for_event(0);
        read_expect(reg_address(0, CONTROL_ADDRESS), exp_control[0], "timer0 control");
        write_reg(0, CONTROL_ADDRESS, 32'h5, 4'h1);
        check_word("irq", word_t'(irq), 32'h1);
        write_reg(0, CONTROL_ADDRESS, 32'h4, 4'h1);   // stop but keep irq_enable.
        check_word("irq", word_t'(irq), 32'h1);

        write_reg(0, STATUS_ADDRESS, 32'h1, 4'he);
        read_expect(reg_address(0, STATUS_ADDRESS), exp_status[0], "timer0 status");
        check_word("irq", word_t'(irq), 32'h1);
        write_reg(0, STATUS_ADDRESS, 32'h1, 4'h1);
        check_word("irq", word_t'(irq), '0);
        read_expect(reg_address(0, STATUS_ADDRESS), exp_status[0], "timer0 status");

        // one-shot on timer 0.
        write_reg(0, REFILL_ADDRESS, 32'd3, 4'hf);
        write_reg(0, CONTROL_ADDRESS, (exp_control[0] & ~32'h7) | 32'h3, 4'hf);
        wait_for_event(0);
        exp_control[0] = exp_control[0] & ~32'h1;
        check_timer_regs(0);
        check_timer_regs(1);

        axil_write(12'h020, next_random(), 4'hf, 0, resp);
        check_word("bresp at 0x020", word_t'(resp), word_t'(SLVERR));
        axil_read(12'h020, data, resp);
        check_word("rresp at 0x020", word_t'(resp), word_t'(SLVERR));
        check_word("rdata at 0x020", data, '0);
        axil_read(12'hffc, data, resp);
        check_word("rresp at 0xffc", word_t'(resp), word_t'(SLVERR));
        check_word("rdata at 0xffc", data, '0);
        axil_write(12'h7f0, next_random(), 4'hf, 4, resp);
        check_word("bresp at 0x7f0", word_t'(resp), word_t'(SLVERR));
        check_timer_regs(0);
        check_timer_regs(1);

        $display("errors: value %0d protocol %0d timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* timer_subsystem.f */
+incdir+tb
source/periph_types_pkg.sv
source/timer_pkg.sv
source/periph_bus_if.sv
source/axil_bus_bridge.sv
source/periph_decoder.sv
source/interval_timer.sv
source/timer_subsystem.sv
tb/timer_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the timer subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f timer_subsystem.f \
    --top-module timer_subsystem_tb -o timer_sim > build.log 2>&1 ||
    { cat build.log; echo "build error"; exit 1; }
./obj_dir/timer_sim > sim.log 2>&1 ||
    echo "simulator exited with an error"
cat sim.log
grep -qx "sim passed" sim.log && exit 0 ||
    { echo "simulation did not pass"; exit 1; }
